//--- Bender.yml
package:
  name: exec_core

sources:
  - src/exec_pkg.sv
  - src/exec_decode.sv
  - src/exec_regfile.sv
  - src/exec_alu.sv
  - src/exec_branch.sv
  - src/exec_control.sv
  - src/exec_stage.sv
  - target: test
    files:
      - tests/exec_stage_chk.sv
      - tests/exec_stage_tb.sv

//--- exec_core.f
src/exec_pkg.sv
src/exec_decode.sv
src/exec_regfile.sv
src/exec_alu.sv
src/exec_branch.sv
src/exec_control.sv
src/exec_stage.sv
tests/exec_stage_chk.sv
tests/exec_stage_tb.sv

//--- src/exec_alu.sv
`default_nettype none

module exec_alu (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  exec_pkg::fetch_t          fetch,
    input  exec_pkg::decoded_t        dec,
    input  logic [exec_pkg::XLEN-1:0] rs1_data,
    input  logic [exec_pkg::XLEN-1:0] rs2_data,
    output exec_pkg::unit_out_t       out
);

    import exec_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] sra_res;
    logic [XLEN-1:0] res;
    logic [4:0]      shamt;
    logic            sub_sel;
    logic            fire;

    assign fire = issue && dec.is_alu;

    always_comb begin
        op_b    = (dec.opcode == OP_OP) ? rs2_data : dec.i_imm;
        shamt   = op_b[4:0];
        sub_sel = (dec.opcode == OP_OP) && dec.funct7_5; // SUB has no immediate form
        sra_res = $signed(rs1_data) >>> shamt;

        case (dec.opcode)
            OP_LUI:   res = dec.u_imm;
            OP_AUIPC: res = fetch.addr + dec.u_imm;
            default: begin
                case (dec.funct3)
                    3'b000:  res = sub_sel ? rs1_data - op_b : rs1_data + op_b;
                    3'b001:  res = rs1_data << shamt;
                    3'b010:  res = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
                    3'b011:  res = {{(XLEN-1){1'b0}}, rs1_data < op_b};
                    3'b100:  res = rs1_data ^ op_b;
                    3'b101:  res = dec.funct7_5 ? sra_res : rs1_data >> shamt;
                    3'b110:  res = rs1_data | op_b;
                    default: res = rs1_data & op_b;
                endcase
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out.rd        <= dec.rd;
            out.we        <= dec.legal_opcode;
            out.result    <= res;
            out.exception <= !dec.legal_opcode;
            out.cause     <= EXC_ILLEGAL_INSTR; // Only cause this unit raises
            out.taken     <= 1'b0;
            out.target    <= '0;
        end

        if (rst)
            out.valid <= 1'b0;
        else
            out.valid <= fire;
    end

endmodule

`default_nettype wire

//--- src/exec_branch.sv
`default_nettype none

module exec_branch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_unless_mispredict,
    input  logic                      issue,
    input  exec_pkg::fetch_t          fetch,
    input  exec_pkg::decoded_t        dec,
    input  logic [exec_pkg::XLEN-1:0] rs1_data,
    input  logic [exec_pkg::XLEN-1:0] rs2_data,
    output exec_pkg::unit_out_t       out,
    output logic                      mispredict
);

    import exec_pkg::*;

    logic [ALEN-1:0] add_a;
    logic [ALEN-1:0] add_b;
    logic [ALEN-1:0] sum;
    logic [ALEN-1:0] target;
    logic            cond;
    logic            illegal;
    logic            misaligned;
    logic            exc;
    logic            taken_now;
    logic            fire;
    logic            taken_q;
    logic [ALEN-1:0] target_q;

    assign fire = issue && dec.is_branch;

    // Single target adder shared by all three forms
    always_comb begin
        case (dec.opcode)
            OP_JALR: begin
                add_a = rs1_data;
                add_b = dec.i_imm;
            end
            OP_JAL: begin
                add_a = fetch.addr;
                add_b = dec.j_imm;
            end
            default: begin
                add_a = fetch.addr;
                add_b = dec.b_imm;
            end
        endcase
        sum    = add_a + add_b;
        target = (dec.opcode == OP_JALR) ? {sum[ALEN-1:1], 1'b0} : sum;
    end

    always_comb begin
        if (dec.opcode == OP_BRANCH) begin
            case (dec.funct3)
                3'b000:  cond = rs1_data == rs2_data;                   // BEQ
                3'b001:  cond = rs1_data != rs2_data;                   // BNE
                3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);  // BLT
                3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data); // BGE
                3'b110:  cond = rs1_data < rs2_data;                    // BLTU
                3'b111:  cond = rs1_data >= rs2_data;                   // BGEU
                default: cond = 1'b0;
            endcase
        end else begin
            cond = 1'b1; // Jumps always taken
        end

        illegal = ((dec.opcode == OP_JALR) && (dec.funct3 != 3'b000))
               || ((dec.opcode == OP_BRANCH) && (dec.funct3[2:1] == 2'b01));
        misaligned = cond && target[1]; // No compressed support
        exc        = illegal || misaligned;
        taken_now  = cond && !exc;
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out.rd        <= dec.rd;
            out.we        <= (dec.opcode != OP_BRANCH) && !exc;
            out.result    <= fetch.next_addr; // Link value, not the target
            out.exception <= exc;
            out.cause     <= illegal ? EXC_ILLEGAL_INSTR : EXC_INSTR_ADDR_MISALIGNED;
            out.taken     <= taken_now;
            out.target    <= target;
        end

        if (rst)
            out.valid <= 1'b0;
        else
            out.valid <= fire;
    end

    // Last taken target, checked against the next presented address
    always_ff @(posedge clk) begin
        if (fire && taken_now)
            target_q <= target;

        if (rst)
            taken_q <= 1'b0;
        else if (issue_unless_mispredict)
            taken_q <= fire && taken_now;
    end

    assign mispredict = issue_unless_mispredict && taken_q && (fetch.addr != target_q);

endmodule

`default_nettype wire

//--- src/exec_control.sv
`default_nettype none

module exec_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [exec_pkg::ALEN-1:0] in_addr,
    input  logic                      trap_clear,
    input  logic                      mispredict,
    input  exec_pkg::unit_out_t       alu_out,
    input  exec_pkg::unit_out_t       branch_out,
    output logic                      issue_unless_mispredict,
    output logic                      issue,
    output exec_pkg::retire_t         retire,
    output logic                      halted
);

    import exec_pkg::*;

    ctrl_state_e     state;
    unit_out_t       sel;
    logic [ALEN-1:0] addr_q;
    logic            trap_now;

    // At most one unit is valid per cycle
    assign sel      = branch_out.valid ? branch_out : alu_out;
    assign trap_now = sel.valid && sel.exception;

    // Trap blocks issue already in the cycle it retires
    assign halted                  = (state == HALTED) || trap_now;
    assign issue_unless_mispredict = in_valid && !halted;
    assign issue                   = issue_unless_mispredict && !mispredict;

    always_comb begin
        retire.valid     = sel.valid;
        retire.rd        = sel.rd;
        retire.we        = sel.valid && sel.we;
        retire.result    = sel.result;
        retire.exception = sel.exception;
        retire.cause     = sel.cause;
        retire.taken     = sel.taken;
        retire.target    = sel.target;
        retire.addr      = addr_q;
    end

    always_ff @(posedge clk) begin
        if (issue)
            addr_q <= in_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
        end else begin
            case (state)
                RUN: begin
                    if (trap_now)
                        state <= HALTED;
                end
                HALTED: begin
                    if (trap_clear)
                        state <= RUN;
                end
                default: state <= RUN;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/exec_decode.sv
`default_nettype none

module exec_decode (
    input  logic [31:0]         instr,
    output exec_pkg::decoded_t  dec
);

    import exec_pkg::*;

    logic known;
    logic branch_op;

    always_comb begin
        dec.opcode   = opcode_e'(instr[6:2]);
        dec.rd       = instr[11:7];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.funct3   = instr[14:12];
        dec.funct7_5 = instr[30];

        dec.i_imm = {{(XLEN-12){instr[31]}}, instr[31:20]};
        dec.b_imm = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                     instr[11:8], 1'b0};
        dec.j_imm = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                     instr[30:21], 1'b0};
        dec.u_imm = {instr[31:12], 12'h000};

        case (dec.opcode)
            OP_JAL, OP_JALR, OP_BRANCH: begin
                branch_op = 1'b1;
                known     = 1'b1;
            end
            OP_LUI, OP_AUIPC, OP_IMM, OP_OP: begin
                branch_op = 1'b0;
                known     = 1'b1;
            end
            default: begin
                branch_op = 1'b0;
                known     = 1'b0;
            end
        endcase

        // Low bits must be 11, no compressed encodings
        dec.legal_opcode = known && (instr[1:0] == 2'b11);
        dec.is_branch    = branch_op && dec.legal_opcode;
        dec.is_alu       = !dec.is_branch; // Unknown words retire as ALU traps
    end

endmodule

`default_nettype wire

//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN = 32;
    localparam int ALEN = 32;

    // Instruction bits 6:2
    typedef enum logic [4:0] {
        OP_LUI    = 5'b01101,
        OP_AUIPC  = 5'b00101,
        OP_JAL    = 5'b11011,
        OP_JALR   = 5'b11001,
        OP_BRANCH = 5'b11000,
        OP_IMM    = 5'b00100,
        OP_OP     = 5'b01100
    } opcode_e;

    typedef enum logic [3:0] {
        EXC_INSTR_ADDR_MISALIGNED = 4'd0,
        EXC_ILLEGAL_INSTR         = 4'd2
    } trap_cause_e;

    typedef enum logic {
        RUN,
        HALTED
    } ctrl_state_e;

    typedef struct packed {
        logic [ALEN-1:0] addr;
        logic [ALEN-1:0] next_addr;
        logic            compressed;
        logic [31:0]     word;
    } fetch_t;

    typedef struct packed {
        opcode_e         opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      funct3;
        logic            funct7_5;
        logic [XLEN-1:0] i_imm;
        logic [XLEN-1:0] b_imm;
        logic [XLEN-1:0] j_imm;
        logic [XLEN-1:0] u_imm;
        logic            is_branch;
        logic            is_alu;
        logic            legal_opcode;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] result;
        logic            exception;
        trap_cause_e     cause;
        logic            taken;
        logic [ALEN-1:0] target;
    } unit_out_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] result;
        logic            exception;
        trap_cause_e     cause;
        logic            taken;
        logic [ALEN-1:0] target;
        logic [ALEN-1:0] addr;
    } retire_t;

endpackage

`default_nettype wire

//--- src/exec_regfile.sv
`default_nettype none

module exec_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [4:0]                rs1,
    input  logic [4:0]                rs2,
    output logic [exec_pkg::XLEN-1:0] rs1_data,
    output logic [exec_pkg::XLEN-1:0] rs2_data,
    input  logic                      wr_en,
    input  logic [4:0]                wr_addr,
    input  logic [exec_pkg::XLEN-1:0] wr_data
);

    import exec_pkg::*;

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage
    logic            wr_live;

    assign wr_live = wr_en && (wr_addr != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        if (rs1 == 5'd0)
            rs1_data = '0;
        else if (wr_live && wr_addr == rs1)
            rs1_data = wr_data; // Bypass same-cycle write
        else
            rs1_data = regs[rs1];

        if (rs2 == 5'd0)
            rs2_data = '0;
        else if (wr_live && wr_addr == rs2)
            rs2_data = wr_data;
        else
            rs2_data = regs[rs2];
    end

endmodule

`default_nettype wire

//--- src/exec_stage.sv
`default_nettype none

module exec_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  exec_pkg::fetch_t   in_instr,
    input  logic               trap_clear,
    output exec_pkg::retire_t  retire,
    output logic               mispredict,
    output logic               halted
);

    import exec_pkg::*;

    decoded_t        dec;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    unit_out_t       alu_out;
    unit_out_t       branch_out;
    logic            issue;
    logic            issue_unless_mispredict;

    exec_decode decode0 (
        .instr (in_instr.word),
        .dec   (dec)
    );

    exec_regfile regfile0 (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (retire.we),    // Already qualified by valid
        .wr_addr  (retire.rd),
        .wr_data  (retire.result)
    );

    exec_alu alu0 (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .fetch    (in_instr),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .out      (alu_out)
    );

    exec_branch branch0 (
        .clk                     (clk),
        .rst                     (rst),
        .issue_unless_mispredict (issue_unless_mispredict),
        .issue                   (issue),
        .fetch                   (in_instr),
        .dec                     (dec),
        .rs1_data                (rs1_data),
        .rs2_data                (rs2_data),
        .out                     (branch_out),
        .mispredict              (mispredict)
    );

    exec_control control0 (
        .clk                     (clk),
        .rst                     (rst),
        .in_valid                (in_valid),
        .in_addr                 (in_instr.addr),
        .trap_clear              (trap_clear),
        .mispredict              (mispredict),
        .alu_out                 (alu_out),
        .branch_out              (branch_out),
        .issue_unless_mispredict (issue_unless_mispredict),
        .issue                   (issue),
        .retire                  (retire),
        .halted                  (halted)
    );

endmodule

`default_nettype wire

//--- tests/exec_stage_chk.sv
`default_nettype none

module exec_stage_chk (
    input logic              clk,
    input logic              rst,
    input exec_pkg::retire_t retire,
    input logic              mispredict,
    input logic              halted,
    input exec_pkg::retire_t exp_ret,
    input logic              exp_mis,
    input logic              exp_halted
);

    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    int unsigned failures = 0; // Watched by the testbench

    valid_match: assert property (@(posedge clk) disable iff (rst)
        retire.valid == exp_ret.valid)
    else begin
        $error("retire.valid %b, expected %b", $sampled(retire.valid),
               $sampled(exp_ret.valid));
        failures++;
    end

    record_match: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> (retire.rd == exp_ret.rd) && (retire.we == exp_ret.we)
                         && (retire.exception == exp_ret.exception)
                         && (retire.taken == exp_ret.taken) && (retire.addr == exp_ret.addr))
    else begin
        $error("retire record at %h differs from model", $sampled(exp_ret.addr));
        failures++;
    end

    result_match: assert property (@(posedge clk) disable iff (rst)
        retire.valid && exp_ret.we |-> retire.result == exp_ret.result)
    else begin
        $error("result %h, expected %h", $sampled(retire.result), $sampled(exp_ret.result));
        failures++;
    end

    cause_match: assert property (@(posedge clk) disable iff (rst)
        retire.valid && exp_ret.exception |-> retire.cause == exp_ret.cause)
    else begin
        $error("trap cause %0d, expected %0d", $sampled(retire.cause), $sampled(exp_ret.cause));
        failures++;
    end

    target_match: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> retire.target == exp_ret.target)
    else begin
        $error("target %h, expected %h", $sampled(retire.target), $sampled(exp_ret.target));
        failures++;
    end

    mispredict_match: assert property (@(posedge clk) disable iff (rst)
        mispredict == exp_mis)
    else begin
        $error("mispredict %b, expected %b", $sampled(mispredict), $sampled(exp_mis));
        failures++;
    end

    halted_match: assert property (@(posedge clk) disable iff (rst)
        halted == exp_halted)
    else begin
        $error("halted %b, expected %b", $sampled(halted), $sampled(exp_halted));
        failures++;
    end

    // Outputs quiet right after reset release
    reset_clean: assert property (@(posedge clk)
        $fell(rst) |-> !retire.valid && !mispredict && !halted)
    else begin
        $error("outputs not idle after reset");
        failures++;
    end

endmodule

`default_nettype wire

//--- tests/exec_stage_tb.sv
`default_nettype none

module exec_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam int N_ALU       = 300;
    localparam int N_BR        = 120;
    localparam int N_TRAP      = 14; // 7 JALR, 2 BRANCH, 5 misaligned
    localparam int N_MISP      = 30;
    localparam int TEST_CYCLES = 2 + N_ALU + 2 * N_BR + 5 * N_TRAP + 3 * N_MISP + 4;

    logic    clk;
    logic    rst;
    logic    in_valid;
    fetch_t  in_instr;
    logic    trap_clear;
    retire_t retire;
    logic    mispredict;
    logic    halted;

    // Expectations for the bound checker
    retire_t exp_ret;
    logic    exp_mis;
    logic    exp_halted;

    logic [XLEN-1:0] model_regs [32];
    logic            model_halted;
    logic            model_taken;
    logic [ALEN-1:0] model_target;
    retire_t         pend; // Record of the instruction presented this cycle
    logic [ALEN-1:0] pc;
    logic [31:0]     lfsr;

    exec_stage dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .trap_clear (trap_clear),
        .retire     (retire),
        .mispredict (mispredict),
        .halted     (halted)
    );

    bind exec_stage exec_stage_chk chk0 (
        .clk        (clk),
        .rst        (rst),
        .retire     (retire),
        .mispredict (mispredict),
        .halted     (halted),
        .exp_ret    (exec_stage_tb.exp_ret),
        .exp_mis    (exec_stage_tb.exp_mis),
        .exp_halted (exec_stage_tb.exp_halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Registers limited to x0..x7 so back-to-back dependencies are common
    function automatic logic [31:0] rand_alu_word();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] upper;
        logic [31:0] word;
        rd    = take_bits(3);
        rs1   = take_bits(3);
        rs2   = take_bits(3);
        f3    = take_bits(3);
        alt   = take_bits(1);
        imm   = take_bits(12);
        upper = take_bits(20);
        case (take_bits(2))
            2'd0: word = {upper[19:0], rd, OPC_LUI};
            2'd1: word = {upper[19:0], rd, OPC_AUIPC};
            2'd2: begin
                if (f3 == 3'b001 || f3 == 3'b101)
                    imm[11:5] = {1'b0, alt && f3 == 3'b101, 5'b0}; // Shift forms
                word = enc_i(imm, rs1, f3, rd, OPC_IMM);
            end
            default: word = enc_i({1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2},
                                  rs1, f3, rd, OPC_OP);
        endcase
        return word;
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic sub,
                                                input logic arith, input logic [XLEN-1:0] x,
                                                input logic [XLEN-1:0] y);
        logic [XLEN-1:0] r;
        case (f3)
            3'b000: r = sub ? x - y : x + y;
            3'b001: r = x << y[4:0];
            3'b010: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011: r = (x < y) ? 32'd1 : 32'd0;
            3'b100: r = x ^ y;
            3'b101: begin
                if (arith)
                    r = $signed(x) >>> y[4:0];
                else
                    r = x >> y[4:0];
            end
            3'b110: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input logic [XLEN-1:0] x,
                                         input logic [XLEN-1:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // RV32I reference for one instruction that also writes rd into the model
    task automatic predict(input fetch_t f, input logic go);
        logic [31:0]     w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [ALEN-1:0] tgt;
        logic            cond;
        logic            ill;
        w          = f.word;
        a          = model_regs[w[19:15]];
        b          = model_regs[w[24:20]];
        imm_i      = {{20{w[31]}}, w[31:20]};
        tgt        = '0;
        ill        = 1'b0;
        pend       = '0;
        pend.valid = go;
        pend.rd    = w[11:7];
        pend.addr  = f.addr;
        pend.we    = 1'b1;
        pend.cause = EXC_ILLEGAL_INSTR;
        case (w[6:0])
            OPC_LUI:   pend.result = {w[31:12], 12'h000};
            OPC_AUIPC: pend.result = f.addr + {w[31:12], 12'h000};
            OPC_IMM:   pend.result = alu_ref(w[14:12], 1'b0, w[30], a, imm_i);
            OPC_OP:    pend.result = alu_ref(w[14:12], w[30], w[30], a, b);
            OPC_JAL:   tgt = f.addr + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            OPC_JALR: begin
                tgt = (a + imm_i) & ~32'd1;
                ill = w[14:12] != 3'b000;
            end
            OPC_BRANCH: begin
                tgt = f.addr + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                ill = w[14:13] == 2'b01;
            end
            default: begin
                pend.we        = 1'b0;
                pend.exception = 1'b1;
            end
        endcase
        if (w[6:0] == OPC_JAL || w[6:0] == OPC_JALR || w[6:0] == OPC_BRANCH) begin
            cond           = (w[6:0] == OPC_BRANCH) ? branch_cond(w[14:12], a, b) : 1'b1;
            pend.exception = ill || (cond && tgt[1]);
            pend.cause     = ill ? EXC_ILLEGAL_INSTR : EXC_INSTR_ADDR_MISALIGNED;
            pend.taken     = cond && !pend.exception;
            pend.target    = tgt;
            pend.we        = (w[6:0] != OPC_BRANCH) && !pend.exception;
            pend.result    = f.next_addr; // Link value
        end
        if (go && pend.we && pend.rd != 5'd0)
            model_regs[pend.rd] = pend.result;
    endtask

    // One input cycle with expectations on the 1-cycle retire timing
    task automatic present(input logic valid, input logic [31:0] word,
                           input logic [ALEN-1:0] addr, input logic clear);
        fetch_t f;
        logic   halt_now;
        logic   ium;
        logic   mis;
        f.addr       = addr;
        f.next_addr  = addr + 32'd4;
        f.compressed = 1'b0;
        f.word       = word;
        @(posedge clk);
        halt_now    = model_halted || (pend.valid && pend.exception);
        ium         = valid && !halt_now;
        mis         = ium && model_taken && (addr != model_target);
        exp_ret    <= pend;
        exp_mis    <= mis;
        exp_halted <= halt_now;
        in_valid   <= valid;
        in_instr   <= f;
        trap_clear <= clear;
        if (model_halted)
            model_halted = !clear;
        else
            model_halted = pend.valid && pend.exception;
        predict(f, ium && !mis);
        if (ium)
            model_taken = pend.valid && pend.taken;
        if (pend.valid && pend.taken)
            model_target = pend.target;
        if (pend.valid)
            pc = pend.taken ? pend.target : f.next_addr;
    endtask

    task automatic run_alu(input int n);
        logic valid;
        for (int i = 0; i < n; i++) begin
            valid = take_bits(3) != 0; // Occasional bubble
            present(valid, rand_alu_word(), pc, 1'b0);
        end
    endtask

    task automatic run_branches(input int n);
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] off;
        logic [31:0] word;
        for (int i = 0; i < n; i++) begin
            kind = take_bits(3);
            rd   = take_bits(3);
            rs1  = take_bits(3);
            rs2  = take_bits(3);
            off  = take_bits(11);
            if (kind == 3'd6)
                word = enc_j({{8{off[10]}}, off[10:0], 2'b00}, rd);
            else if (kind == 3'd7)
                // Low offset bits make the sum end in 01 so bit 0 gets cleared
                word = enc_i({off[9:0], 2'd1 - model_regs[rs1][1:0]}, rs1, 3'b000, rd,
                             OPC_JALR);
            else
                word = enc_b({off[10:0], 2'b00}, rs2, rs1, (kind < 3'd2) ? kind : kind + 3'd2);
            present(1'b1, word, pc, 1'b0);
            present(1'b1, rand_alu_word(), pc, 1'b0); // Target or fall-through
        end
    endtask

    // Trap, two ignored inputs, clear pulse, then normal issue
    task automatic trap_and_recover(input logic [31:0] word);
        present(1'b1, word, pc, 1'b0);
        present(1'b1, rand_alu_word(), pc, 1'b0);
        present(1'b1, rand_alu_word(), pc, 1'b0);
        present(1'b1, rand_alu_word(), pc, 1'b1);
        present(1'b1, rand_alu_word(), pc, 1'b0);
    endtask

    always @(dut0.chk0.failures) begin
        if (dut0.chk0.failures != 0) begin
            $display("ERROR at %0t ns: a checker assertion failed", $time);
            $display("Something failed");
            $fatal(1, "Stopping at the first error");
        end
    end

    initial begin
        #(TEST_CYCLES * 40 + 1000);
        $display("Timeout: the test sequence did not finish in time");
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [31:0] off;
        lfsr         = 32'h60f95ca2;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        trap_clear   = 1'b0;
        exp_ret      = '0;
        exp_mis      = 1'b0;
        exp_halted   = 1'b0;
        pend         = '0;
        pc           = 32'h0000_1000;
        model_halted = 1'b0;
        model_taken  = 1'b0;
        model_target = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        run_alu(N_ALU);
        run_branches(N_BR);

        for (int f3 = 1; f3 < 8; f3++) begin
            trap_and_recover(enc_i(12'h010, 5'd0, f3[2:0], 5'd1, OPC_JALR));
        end
        trap_and_recover(enc_b(13'h010, 5'd2, 5'd1, 3'b010));
        trap_and_recover(enc_b(13'h010, 5'd2, 5'd1, 3'b011));
        for (int i = 0; i < 5; i++) begin
            off = take_bits(9);
            trap_and_recover(enc_i({off[8:0], 3'b010}, 5'd0, 3'b000, 5'd3, OPC_JALR));
        end

        // Taken jump, wrong-path input, then the real target
        for (int i = 0; i < N_MISP; i++) begin
            off = take_bits(11);
            present(1'b1, enc_j({{8{off[10]}}, off[10:0], 2'b00}, 5'd5), pc, 1'b0);
            present(1'b1, rand_alu_word(), pc + 32'd4, 1'b0);
            present(1'b1, rand_alu_word(), pc, 1'b0);
        end

        present(1'b0, 32'h0, pc, 1'b0);
        present(1'b0, 32'h0, pc, 1'b0);
        repeat (2) @(posedge clk);
        @(negedge clk); // Last assertion attempt has completed
        if (dut0.chk0.failures == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
